// ==== csr_chk.sv ====
`timescale 1ns/1ps

module csr_chk
  (input   clk_i
   , input reset_i
   , input csr_req_i
   , input csr_ack_o
   , input csr_illegal_o
   , input npc_w_v_o
   );

  int unsigned fail_count = 0;

  // Ack is registered from an edge where req was seen
  ack_rise: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(csr_ack_o) |-> $past(csr_req_i))
  else
  begin
    $error("csr_ack_o rose without csr_req_i high on the previous edge");
    fail_count++;
  end

  ack_fall: assert property (@(posedge clk_i) disable iff (reset_i)
    $fell(csr_ack_o) |-> !$past(csr_req_i))
  else
  begin
    $error("csr_ack_o fell while csr_req_i was still high");
    fail_count++;
  end

  illegal_with_ack: assert property (@(posedge clk_i) disable iff (reset_i)
    csr_illegal_o |-> csr_ack_o)
  else
  begin
    $error("csr_illegal_o high without csr_ack_o");
    fail_count++;
  end

  // Redirect is a single-cycle pulse
  redirect_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
    npc_w_v_o |=> !npc_w_v_o)
  else
  begin
    $error("npc_w_v_o high in two consecutive cycles");
    fail_count++;
  end

endmodule

// ==== csr_cmd_ctrl.sv ====
`timescale 1ns/1ps

module csr_cmd_ctrl
  (input                                       clk_i
   , input                                     reset_i
   , input                                     csr_req_i
   , input csr_pkg::csr_op_e                   csr_op_i
   , input [csr_pkg::csr_addr_width-1:0]       csr_addr_i
   , input [csr_pkg::dword_width-1:0]          csr_wdata_i
   , output logic                              csr_ack_o
   , output logic [csr_pkg::dword_width-1:0]   csr_rdata_o
   , output logic                              csr_illegal_o
   , csr_access_if.cmd                         access
   );

  logic                            ack_r;
  logic                            illegal_r;
  logic [csr_pkg::dword_width-1:0] rdata_r;
  logic                            accept;
  logic                            op_legal;
  logic                            priv_ok;
  logic                            legal;
  logic                            imm_form;
  logic [csr_pkg::dword_width-1:0] src;

  // New access only once the previous ack has dropped
  assign accept = csr_req_i & ~ack_r;

  assign op_legal = csr_op_i inside {csr_pkg::csrrw, csr_pkg::csrrs, csr_pkg::csrrc,
                                     csr_pkg::csrrwi, csr_pkg::csrrsi, csr_pkg::csrrci};
  assign priv_ok  = access.priv >= csr_addr_i[9:8];
  assign legal    = op_legal & access.addr_valid & priv_ok;

  assign imm_form = csr_op_i inside {csr_pkg::csrrwi, csr_pkg::csrrsi, csr_pkg::csrrci};
  assign src      = imm_form ? {{(csr_pkg::dword_width-5){1'b0}}, csr_wdata_i[4:0]}
                             : csr_wdata_i;

  assign access.addr = csr_addr_i;
  assign access.re   = accept;
  assign access.we   = accept & legal;

  // Write data built from the pre-write value
  always_comb
  begin
    unique case (csr_op_i)
      csr_pkg::csrrs, csr_pkg::csrrsi: access.wdata = access.rdata | src;
      csr_pkg::csrrc, csr_pkg::csrrci: access.wdata = access.rdata & ~src;
      default:                         access.wdata = src;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      ack_r     <= 1'b0;
      illegal_r <= 1'b0;
    end
    else if (accept)
    begin
      ack_r     <= 1'b1;
      illegal_r <= ~legal;
    end
    else if (~csr_req_i)
    begin
      ack_r     <= 1'b0;
      illegal_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
      rdata_r <= legal ? access.rdata : '0;
  end

  assign csr_ack_o     = ack_r;
  assign csr_rdata_o   = rdata_r;
  assign csr_illegal_o = illegal_r;

endmodule

// ==== csr_ifs.sv ====
`timescale 1ns/1ps

interface csr_access_if;
  logic                              we;
  logic                              re;
  logic [csr_pkg::csr_addr_width-1:0] addr;
  logic [csr_pkg::dword_width-1:0]   wdata;
  logic [csr_pkg::dword_width-1:0]   rdata;
  logic                              addr_valid;
  csr_pkg::priv_e                    priv;

  modport cmd  (output we, re, addr, wdata, input rdata, addr_valid, priv);
  modport regs (input we, re, addr, wdata, output rdata, addr_valid, priv);
endinterface

interface trap_if;
  logic                            trap_v;
  logic                            trap_irq;
  logic [3:0]                      trap_code;
  logic                            mret_v;
  logic [csr_pkg::dword_width-1:0] mstatus;
  logic [csr_pkg::dword_width-1:0] mie;
  logic [csr_pkg::dword_width-1:0] mip;
  csr_pkg::priv_e                  priv;

  modport trap (output trap_v, trap_irq, trap_code, mret_v, input mstatus, mie, mip, priv);
  modport regs (input trap_v, trap_irq, trap_code, mret_v, output mstatus, mie, mip, priv);
endinterface

// ==== csr_pkg.sv ====
package csr_pkg;

  localparam int dword_width    = 64;
  localparam int csr_addr_width = 12;

  typedef enum logic [2:0] {
    csrrw  = 3'd1,
    csrrs  = 3'd2,
    csrrc  = 3'd3,
    csrrwi = 3'd4,
    csrrsi = 3'd5,
    csrrci = 3'd6
  } csr_op_e;

  typedef enum logic [1:0] {
    priv_u = 2'd0,
    priv_m = 2'd3
  } priv_e;

  localparam logic [csr_addr_width-1:0] addr_mstatus   = 12'h300;
  localparam logic [csr_addr_width-1:0] addr_misa      = 12'h301;
  localparam logic [csr_addr_width-1:0] addr_mie       = 12'h304;
  localparam logic [csr_addr_width-1:0] addr_mtvec     = 12'h305;
  localparam logic [csr_addr_width-1:0] addr_mscratch  = 12'h340;
  localparam logic [csr_addr_width-1:0] addr_mepc      = 12'h341;
  localparam logic [csr_addr_width-1:0] addr_mcause    = 12'h342;
  localparam logic [csr_addr_width-1:0] addr_mip       = 12'h344;
  localparam logic [csr_addr_width-1:0] addr_mcycle    = 12'hb00;
  localparam logic [csr_addr_width-1:0] addr_minstret  = 12'hb02;
  localparam logic [csr_addr_width-1:0] addr_mvendorid = 12'hf11;
  localparam logic [csr_addr_width-1:0] addr_marchid   = 12'hf12;
  localparam logic [csr_addr_width-1:0] addr_mimpid    = 12'hf13;
  localparam logic [csr_addr_width-1:0] addr_mhartid   = 12'hf14;

  // RV64 with I, M and U
  localparam logic [dword_width-1:0] misa_value    = {2'b10, 36'b0, 26'h0101100};
  localparam logic [dword_width-1:0] marchid_value = 64'd13;
  localparam logic [dword_width-1:0] mimpid_value  = 64'd1;

  localparam logic [3:0] ecode_illegal    = 4'd2;
  localparam logic [3:0] ecode_breakpoint = 4'd3;
  localparam logic [3:0] ecode_ecall_u    = 4'd8;
  localparam logic [3:0] ecode_ecall_m    = 4'd11;

  localparam logic [3:0] icode_msi = 4'd3;
  localparam logic [3:0] icode_mti = 4'd7;
  localparam logic [3:0] icode_mei = 4'd11;

  typedef struct packed {
    logic [50:0] rsvd_63_13;
    logic [1:0]  mpp;
    logic [2:0]  rsvd_10_8;
    logic        mpie;
    logic [2:0]  rsvd_6_4;
    logic        mie;
    logic [2:0]  rsvd_2_0;
  } mstatus_s;

  typedef union packed {
    logic [dword_width-1:0] raw;
    mstatus_s               mstatus;
  } csr_word_u;

endpackage

// ==== csr_regfile.sv ====
`timescale 1ns/1ps

module csr_regfile
  #(parameter int vaddr_width_p = 39
    , parameter logic [63:0] boot_pc_p = 64'h8000_0000
    , parameter logic [63:0] hart_id_p = 64'd0
    )
  (input                              clk_i
   , input                            reset_i
   , input                            retire_v_i
   , input [vaddr_width_p-1:0]        retire_npc_i
   , input                            timer_irq_i
   , input                            software_irq_i
   , input                            external_irq_i
   , output logic [vaddr_width_p-1:0] npc_o
   , output logic                     npc_w_v_o
   , output csr_pkg::priv_e           priv_o
   , csr_access_if.regs               access
   , trap_if.regs                     trap
   );

  localparam int dw = csr_pkg::dword_width;
  localparam logic [dw-1:0] mie_mask = (dw'(1) << csr_pkg::icode_msi)
                                     | (dw'(1) << csr_pkg::icode_mti)
                                     | (dw'(1) << csr_pkg::icode_mei);

  csr_pkg::priv_e           priv_r;
  csr_pkg::mstatus_s        mstatus_r;
  csr_pkg::csr_word_u       wdata_w;
  logic [vaddr_width_p-1:0] pc_r;
  logic                     npc_w_v_r;
  logic [dw-1:0]            mie_r, mtvec_r, mscratch_r, mepc_r, mcause_r;
  logic [dw-1:0]            mcycle_r, minstret_r;
  logic                     msip_r, mtip_r, meip_r;
  logic [dw-1:0]            mip_w;
  logic [dw-1:0]            rd_val;

  always_comb
  begin
    mip_w                     = '0;
    mip_w[csr_pkg::icode_msi] = msip_r;
    mip_w[csr_pkg::icode_mti] = mtip_r;
    mip_w[csr_pkg::icode_mei] = meip_r;
  end

  // Read mux and address decode
  always_comb
  begin
    rd_val            = '0;
    access.addr_valid = 1'b1;
    unique case (access.addr)
      csr_pkg::addr_mstatus:   rd_val = mstatus_r;
      csr_pkg::addr_misa:      rd_val = csr_pkg::misa_value;
      csr_pkg::addr_mie:       rd_val = mie_r;
      csr_pkg::addr_mtvec:     rd_val = mtvec_r;
      csr_pkg::addr_mscratch:  rd_val = mscratch_r;
      csr_pkg::addr_mepc:      rd_val = mepc_r;
      csr_pkg::addr_mcause:    rd_val = mcause_r;
      csr_pkg::addr_mip:       rd_val = mip_w;
      csr_pkg::addr_mcycle:    rd_val = mcycle_r;
      csr_pkg::addr_minstret:  rd_val = minstret_r;
      csr_pkg::addr_mvendorid: rd_val = '0;
      csr_pkg::addr_marchid:   rd_val = csr_pkg::marchid_value;
      csr_pkg::addr_mimpid:    rd_val = csr_pkg::mimpid_value;
      csr_pkg::addr_mhartid:   rd_val = hart_id_p;
      default:                 access.addr_valid = 1'b0;
    endcase
  end

  assign access.rdata = access.re ? rd_val : '0;
  assign wdata_w.raw  = access.wdata;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      priv_r     <= csr_pkg::priv_m;
      pc_r       <= boot_pc_p[vaddr_width_p-1:0];
      npc_w_v_r  <= 1'b0;
      mstatus_r  <= '0;
      mie_r      <= '0;
      mtvec_r    <= '0;
      mscratch_r <= '0;
      mepc_r     <= '0;
      mcause_r   <= '0;
      mcycle_r   <= '0;
      minstret_r <= '0;
      msip_r     <= 1'b0;
      mtip_r     <= 1'b0;
      meip_r     <= 1'b0;
    end
    else
    begin
      mcycle_r <= mcycle_r + 1'b1;
      if (retire_v_i & ~trap.trap_v)
        minstret_r <= minstret_r + 1'b1;
      msip_r    <= software_irq_i;
      mtip_r    <= timer_irq_i;
      meip_r    <= external_irq_i;
      npc_w_v_r <= trap.trap_v | trap.mret_v;

      // Read-only and unknown addresses fall through untouched
      if (access.we)
      begin
        case (access.addr)
          csr_pkg::addr_mstatus:
          begin
            mstatus_r.mie  <= wdata_w.mstatus.mie;
            mstatus_r.mpie <= wdata_w.mstatus.mpie;
            mstatus_r.mpp  <= wdata_w.mstatus.mpp[1] ? csr_pkg::priv_m : csr_pkg::priv_u;
          end
          csr_pkg::addr_mie:      mie_r      <= access.wdata & mie_mask;
          csr_pkg::addr_mtvec:    mtvec_r    <= access.wdata;
          csr_pkg::addr_mscratch: mscratch_r <= access.wdata;
          csr_pkg::addr_mepc:     mepc_r     <= access.wdata;
          csr_pkg::addr_mcause:   mcause_r   <= access.wdata;
          csr_pkg::addr_mcycle:   mcycle_r   <= access.wdata;
          csr_pkg::addr_minstret: minstret_r <= access.wdata;
          default:
          begin
          end
        endcase
      end

      // Trap and mret come last so they win over a same-edge write
      if (trap.trap_v)
      begin
        priv_r         <= csr_pkg::priv_m;
        mepc_r         <= {{(dw-vaddr_width_p){1'b0}}, pc_r};
        mcause_r       <= {trap.trap_irq, {(dw-5){1'b0}}, trap.trap_code};
        mstatus_r.mpp  <= priv_r;
        mstatus_r.mpie <= mstatus_r.mie;
        mstatus_r.mie  <= 1'b0;
        pc_r           <= {mtvec_r[vaddr_width_p-1:2], 2'b00};
      end
      else if (trap.mret_v)
      begin
        priv_r         <= csr_pkg::priv_e'(mstatus_r.mpp);
        mstatus_r.mpp  <= csr_pkg::priv_u;
        mstatus_r.mie  <= mstatus_r.mpie;
        mstatus_r.mpie <= 1'b1;
        pc_r           <= mepc_r[vaddr_width_p-1:0];
      end
      else if (retire_v_i)
        pc_r <= retire_npc_i;
    end
  end

  assign access.priv  = priv_r;
  assign trap.priv    = priv_r;
  assign trap.mstatus = mstatus_r;
  assign trap.mie     = mie_r;
  assign trap.mip     = mip_w;

  assign npc_o     = pc_r;
  assign npc_w_v_o = npc_w_v_r;
  assign priv_o    = priv_r;

endmodule

// ==== csr_top.sv ====
`timescale 1ns/1ps

module csr_top
  #(parameter int vaddr_width_p = 39
    , parameter logic [63:0] boot_pc_p = 64'h8000_0000
    , parameter logic [63:0] hart_id_p = 64'd0
    )
  (input                                      clk_i
   , input                                    reset_i
   , input                                    csr_req_i
   , input csr_pkg::csr_op_e                  csr_op_i
   , input [csr_pkg::csr_addr_width-1:0]      csr_addr_i
   , input [csr_pkg::dword_width-1:0]         csr_wdata_i
   , output logic                             csr_ack_o
   , output logic [csr_pkg::dword_width-1:0]  csr_rdata_o
   , output logic                             csr_illegal_o
   , input                                    retire_v_i
   , input [vaddr_width_p-1:0]                retire_npc_i
   , input                                    retire_illegal_i
   , input                                    retire_ebreak_i
   , input                                    retire_ecall_i
   , input                                    retire_mret_i
   , input                                    interrupt_v_i
   , input                                    timer_irq_i
   , input                                    software_irq_i
   , input                                    external_irq_i
   , output logic                             irq_pending_o
   , output logic [vaddr_width_p-1:0]         npc_o
   , output logic                             npc_w_v_o
   , output csr_pkg::priv_e                   priv_o
   );

  csr_access_if access_bus ();
  trap_if       trap_bus ();

  csr_cmd_ctrl cmd_ctrl
    (.clk_i(clk_i)
     , .reset_i(reset_i)
     , .csr_req_i(csr_req_i)
     , .csr_op_i(csr_op_i)
     , .csr_addr_i(csr_addr_i)
     , .csr_wdata_i(csr_wdata_i)
     , .csr_ack_o(csr_ack_o)
     , .csr_rdata_o(csr_rdata_o)
     , .csr_illegal_o(csr_illegal_o)
     , .access(access_bus.cmd)
     );

  csr_trap_unit trap_unit
    (.retire_v_i(retire_v_i)
     , .retire_illegal_i(retire_illegal_i)
     , .retire_ebreak_i(retire_ebreak_i)
     , .retire_ecall_i(retire_ecall_i)
     , .retire_mret_i(retire_mret_i)
     , .interrupt_v_i(interrupt_v_i)
     , .irq_pending_o(irq_pending_o)
     , .trap(trap_bus.trap)
     );

  csr_regfile
    #(.vaddr_width_p(vaddr_width_p)
      , .boot_pc_p(boot_pc_p)
      , .hart_id_p(hart_id_p)
      )
    regfile
    (.clk_i(clk_i)
     , .reset_i(reset_i)
     , .retire_v_i(retire_v_i)
     , .retire_npc_i(retire_npc_i)
     , .timer_irq_i(timer_irq_i)
     , .software_irq_i(software_irq_i)
     , .external_irq_i(external_irq_i)
     , .npc_o(npc_o)
     , .npc_w_v_o(npc_w_v_o)
     , .priv_o(priv_o)
     , .access(access_bus.regs)
     , .trap(trap_bus.regs)
     );

endmodule

// ==== csr_trap_unit.sv ====
`timescale 1ns/1ps

module csr_trap_unit
  (input          retire_v_i
   , input        retire_illegal_i
   , input        retire_ebreak_i
   , input        retire_ecall_i
   , input        retire_mret_i
   , input        interrupt_v_i
   , output logic irq_pending_o
   , trap_if.trap trap
   );

  // Valid bit on top, lowest set index below
  function automatic logic [4:0] lowest_set(input logic [15:0] vec);
    logic [4:0] res;
    res = '0;
    for (int i = 15; i >= 0; i--)
    begin
      if (vec[i])
        res = {1'b1, 4'(i)};
    end
    return res;
  endfunction

  csr_pkg::csr_word_u status_w;
  logic               is_m_mode;
  logic               gie;
  logic [15:0]        irq_vec;
  logic [15:0]        exc_vec;
  logic [4:0]         irq_enc;
  logic [4:0]         exc_enc;
  logic               irq_take;

  assign status_w.raw = trap.mstatus;
  assign is_m_mode    = (trap.priv == csr_pkg::priv_m);

  // U mode always sees M interrupts enabled
  assign gie = (is_m_mode & status_w.mstatus.mie) | ~is_m_mode;

  assign irq_vec       = trap.mie[15:0] & trap.mip[15:0] & {16{gie}};
  assign irq_pending_o = |irq_vec;

  always_comb
  begin
    exc_vec                            = '0;
    exc_vec[csr_pkg::ecode_illegal]    = retire_v_i & retire_illegal_i;
    exc_vec[csr_pkg::ecode_breakpoint] = retire_v_i & retire_ebreak_i;
    exc_vec[csr_pkg::ecode_ecall_u]    = retire_v_i & retire_ecall_i & ~is_m_mode;
    exc_vec[csr_pkg::ecode_ecall_m]    = retire_v_i & retire_ecall_i & is_m_mode;
  end

  assign irq_enc = lowest_set(irq_vec);
  assign exc_enc = lowest_set(exc_vec);

  // Interrupt beats any exception of the same cycle
  assign irq_take = interrupt_v_i & irq_enc[4];

  assign trap.trap_v    = irq_take | exc_enc[4];
  assign trap.trap_irq  = irq_take;
  assign trap.trap_code = irq_take ? irq_enc[3:0] : exc_enc[3:0];
  assign trap.mret_v    = retire_v_i & retire_mret_i & ~trap.trap_v;

endmodule

// ==== files.f ====
csr_pkg.sv
csr_ifs.sv
csr_cmd_ctrl.sv
csr_trap_unit.sv
csr_regfile.sv
csr_top.sv
csr_chk.sv
tb_csr.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_csr -o sim_csr

out=$(./obj_dir/sim_csr 2>&1)
echo "$out"

if echo "$out" | grep -qx "RESULT: PASS"; then
  exit 0
else
  exit 1
fi

// ==== tb_csr.sv ====
`timescale 1ns/1ps

module tb_csr;

  localparam int          vaddr_width    = 39;
  localparam logic [63:0] boot_pc        = 64'h8000_0000;
  localparam int          test_count     = 6;
  localparam int          cycles_per_test = 300;
  localparam int          timeout_cycles = test_count * cycles_per_test + 200;

  logic                   clk_i;
  logic                   reset_i;
  logic                   csr_req_i;
  csr_pkg::csr_op_e       csr_op_i;
  logic [11:0]            csr_addr_i;
  logic [63:0]            csr_wdata_i;
  logic                   csr_ack_o;
  logic [63:0]            csr_rdata_o;
  logic                   csr_illegal_o;
  logic                   retire_v_i;
  logic [vaddr_width-1:0] retire_npc_i;
  logic                   retire_illegal_i;
  logic                   retire_ebreak_i;
  logic                   retire_ecall_i;
  logic                   retire_mret_i;
  logic                   interrupt_v_i;
  logic                   timer_irq_i;
  logic                   software_irq_i;
  logic                   external_irq_i;
  logic                   irq_pending_o;
  logic [vaddr_width-1:0] npc_o;
  logic                   npc_w_v_o;
  csr_pkg::priv_e         priv_o;

  int cycle_count  = 0;
  int test_errors  = 0;
  int total_errors = 0;
  int tests_passed = 0;
  int tests_failed = 0;

  // Reference state
  logic [63:0] model_scratch = '0;
  logic [63:0] model_tvec    = '0;
  logic [63:0] model_epc     = '0;
  logic [63:0] model_pc      = boot_pc;
  logic        model_mie     = 1'b0;
  logic        model_mpie    = 1'b0;
  logic [1:0]  model_mpp     = 2'd0;
  logic [1:0]  model_priv    = 2'd3;

  csr_pkg::csr_op_e ops [6] = '{csr_pkg::csrrw, csr_pkg::csrrs, csr_pkg::csrrc,
                                csr_pkg::csrrwi, csr_pkg::csrrsi, csr_pkg::csrrci};

  csr_top DUT
    (.clk_i(clk_i), .reset_i(reset_i), .csr_req_i(csr_req_i), .csr_op_i(csr_op_i)
     , .csr_addr_i(csr_addr_i), .csr_wdata_i(csr_wdata_i), .csr_ack_o(csr_ack_o)
     , .csr_rdata_o(csr_rdata_o), .csr_illegal_o(csr_illegal_o), .retire_v_i(retire_v_i)
     , .retire_npc_i(retire_npc_i), .retire_illegal_i(retire_illegal_i)
     , .retire_ebreak_i(retire_ebreak_i), .retire_ecall_i(retire_ecall_i)
     , .retire_mret_i(retire_mret_i), .interrupt_v_i(interrupt_v_i)
     , .timer_irq_i(timer_irq_i), .software_irq_i(software_irq_i)
     , .external_irq_i(external_irq_i), .irq_pending_o(irq_pending_o), .npc_o(npc_o)
     , .npc_w_v_o(npc_w_v_o), .priv_o(priv_o)
     );

  bind csr_top csr_chk chk
    (.clk_i(clk_i), .reset_i(reset_i), .csr_req_i(csr_req_i), .csr_ack_o(csr_ack_o)
     , .csr_illegal_o(csr_illegal_o), .npc_w_v_o(npc_w_v_o)
     );

  initial
  begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i)
  begin
    cycle_count++;
    if (cycle_count >= timeout_cycles)
    begin
      $display("timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  function automatic logic [63:0] apply_op(input csr_pkg::csr_op_e op, input logic [63:0] old,
                                           input logic [63:0] data);
    logic [63:0] imm;
    imm = {59'd0, data[4:0]};
    case (op)
      csr_pkg::csrrw:  return data;
      csr_pkg::csrrs:  return old | data;
      csr_pkg::csrrc:  return old & ~data;
      csr_pkg::csrrwi: return imm;
      csr_pkg::csrrsi: return old | imm;
      csr_pkg::csrrci: return old & ~imm;
      default:         return old;
    endcase
  endfunction

  function automatic logic [63:0] model_status();
    logic [63:0] w;
    w        = '0;
    w[3]     = model_mie;
    w[7]     = model_mpie;
    w[12:11] = model_mpp;
    return w;
  endfunction

  task automatic model_status_write(input logic [63:0] w);
    model_mie  = w[3];
    model_mpie = w[7];
    model_mpp  = w[12] ? 2'd3 : 2'd0;
  endtask

  // Trap takes the current PC and jumps to the aligned vector
  task automatic model_trap();
    model_epc  = model_pc;
    model_mpp  = model_priv;
    model_mpie = model_mie;
    model_mie  = 1'b0;
    model_priv = 2'd3;
    model_pc   = model_tvec & ~64'h3;
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp)
    else
    begin
      $display("error %s expected %h actual %h", name, exp, act);
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    $display("test %s: %s (%0d errors)", name, (test_errors == 0) ? "pass" : "fail",
             test_errors);
    total_errors += test_errors;
    if (test_errors == 0)
      tests_passed++;
    else
      tests_failed++;
    test_errors = 0;
  endtask

  // Full four-phase sequence
  task automatic csr_access(input csr_pkg::csr_op_e op, input logic [11:0] addr,
                            input logic [63:0] wdata, output logic [63:0] rdata,
                            output logic illegal);
    @(posedge clk_i);
    csr_req_i   <= 1'b1;
    csr_op_i    <= op;
    csr_addr_i  <= addr;
    csr_wdata_i <= wdata;
    do
      @(negedge clk_i);
    while (!csr_ack_o);
    rdata   = csr_rdata_o;
    illegal = csr_illegal_o;
    @(posedge clk_i);
    csr_req_i <= 1'b0;
    do
      @(negedge clk_i);
    while (csr_ack_o);
  endtask

  task automatic expect_access(input string name, input csr_pkg::csr_op_e op,
                               input logic [11:0] addr, input logic [63:0] wdata,
                               input logic [63:0] exp_rdata, input logic exp_illegal);
    logic [63:0] rdata;
    logic        illegal;
    csr_access(op, addr, wdata, rdata, illegal);
    check_value(name, exp_rdata, rdata);
    check_value(name, 64'(exp_illegal), 64'(illegal));
  endtask

  task automatic retire(input logic [vaddr_width-1:0] npc, input logic illegal,
                        input logic ecall, input logic mret, output logic redirect);
    @(posedge clk_i);
    retire_v_i       <= 1'b1;
    retire_npc_i     <= npc;
    retire_illegal_i <= illegal;
    retire_ecall_i   <= ecall;
    retire_mret_i    <= mret;
    @(posedge clk_i);
    retire_v_i       <= 1'b0;
    retire_illegal_i <= 1'b0;
    retire_ecall_i   <= 1'b0;
    retire_mret_i    <= 1'b0;
    @(negedge clk_i);
    redirect = npc_w_v_o;
  endtask

  task automatic take_interrupt(output logic redirect);
    @(posedge clk_i);
    interrupt_v_i <= 1'b1;
    @(posedge clk_i);
    interrupt_v_i <= 1'b0;
    @(negedge clk_i);
    redirect = npc_w_v_o;
  endtask

  initial
  begin
    logic [63:0]            data;
    logic                   redirect;
    int                     checker_fails;

    void'($urandom(59197));
    reset_i          <= 1'b1;
    csr_req_i        <= 1'b0;
    csr_op_i         <= csr_pkg::csrrw;
    csr_addr_i       <= '0;
    csr_wdata_i      <= '0;
    retire_v_i       <= 1'b0;
    retire_npc_i     <= '0;
    retire_illegal_i <= 1'b0;
    retire_ebreak_i  <= 1'b0;
    retire_ecall_i   <= 1'b0;
    retire_mret_i    <= 1'b0;
    interrupt_v_i    <= 1'b0;
    timer_irq_i      <= 1'b0;
    software_irq_i   <= 1'b0;
    external_irq_i   <= 1'b0;
    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;

    @(negedge clk_i);
    check_value("reset_state", '0, {csr_ack_o, csr_illegal_o, npc_w_v_o, irq_pending_o});
    check_value("reset_state", 64'd3, 64'(priv_o));
    check_value("reset_state", boot_pc, 64'(npc_o));
    expect_access("reset_state", csr_pkg::csrrs, csr_pkg::addr_mstatus, '0, '0, 1'b0);
    expect_access("reset_state", csr_pkg::csrrs, csr_pkg::addr_mscratch, '0, '0, 1'b0);
    expect_access("reset_state", csr_pkg::csrrs, csr_pkg::addr_misa, '0,
                  csr_pkg::misa_value, 1'b0);
    expect_access("reset_state", csr_pkg::csrrs, csr_pkg::addr_marchid, '0,
                  csr_pkg::marchid_value, 1'b0);
    finish_test("reset_state");

    // Immediate forms see full random words to exercise zero extension
    foreach (ops[i])
    begin
      data = {$urandom, $urandom};
      expect_access("csr_ops", ops[i], csr_pkg::addr_mscratch, data, model_scratch, 1'b0);
      model_scratch = apply_op(ops[i], model_scratch, data);
    end
    expect_access("csr_ops", csr_pkg::csrrs, csr_pkg::addr_mscratch, '0, model_scratch, 1'b0);
    finish_test("csr_ops");

    data = {$urandom, $urandom};
    expect_access("illegal", csr_pkg::csrrw, 12'h7c0, data, '0, 1'b1);
    expect_access("illegal", csr_pkg::csr_op_e'(3'd0), csr_pkg::addr_mscratch, data, '0, 1'b1);
    expect_access("illegal", csr_pkg::csrrs, csr_pkg::addr_mscratch, '0, model_scratch, 1'b0);
    expect_access("illegal", csr_pkg::csrrw, csr_pkg::addr_marchid, data,
                  csr_pkg::marchid_value, 1'b0);
    expect_access("illegal", csr_pkg::csrrs, csr_pkg::addr_marchid, '0,
                  csr_pkg::marchid_value, 1'b0);
    finish_test("illegal");

    expect_access("enter_u_ecall", csr_pkg::csrrw, csr_pkg::addr_mtvec, 64'h8000_1003,
                  model_tvec, 1'b0);
    model_tvec = 64'h8000_1003;
    expect_access("enter_u_ecall", csr_pkg::csrrw, csr_pkg::addr_mepc, 64'h8000_2000,
                  model_epc, 1'b0);
    model_epc = 64'h8000_2000;
    expect_access("enter_u_ecall", csr_pkg::csrrw, csr_pkg::addr_mstatus, '0,
                  model_status(), 1'b0);
    model_status_write('0);
    retire(39'h12_3456_7000, 1'b0, 1'b0, 1'b1, redirect);
    model_priv = model_mpp;
    model_mie  = model_mpie;
    model_mpie = 1'b1;
    model_mpp  = 2'd0;
    model_pc   = 64'(model_epc[vaddr_width-1:0]);
    check_value("enter_u_ecall", 64'd1, 64'(redirect));
    check_value("enter_u_ecall", 64'(model_priv), 64'(priv_o));
    check_value("enter_u_ecall", model_pc, 64'(npc_o));
    expect_access("enter_u_ecall", csr_pkg::csrrs, csr_pkg::addr_mscratch, '0, '0, 1'b1);
    retire(39'h12_3456_8000, 1'b0, 1'b1, 1'b0, redirect);
    model_trap();
    check_value("enter_u_ecall", 64'd1, 64'(redirect));
    check_value("enter_u_ecall", model_pc, 64'(npc_o));
    check_value("enter_u_ecall", 64'd3, 64'(priv_o));
    expect_access("enter_u_ecall", csr_pkg::csrrs, csr_pkg::addr_mcause, '0, 64'd8, 1'b0);
    expect_access("enter_u_ecall", csr_pkg::csrrs, csr_pkg::addr_mepc, '0, model_epc, 1'b0);
    expect_access("enter_u_ecall", csr_pkg::csrrs, csr_pkg::addr_mstatus, '0,
                  model_status(), 1'b0);
    finish_test("enter_u_ecall");

    // Plain retire first, so mepc takes its npc
    retire(39'h00_8000_4000, 1'b0, 1'b0, 1'b0, redirect);
    model_pc = 64'h8000_4000;
    check_value("priority", 64'd0, 64'(redirect));
    check_value("priority", model_pc, 64'(npc_o));
    retire(39'h00_8000_4004, 1'b1, 1'b1, 1'b0, redirect);
    model_trap();
    check_value("priority", 64'd1, 64'(redirect));
    check_value("priority", model_pc, 64'(npc_o));
    expect_access("priority", csr_pkg::csrrs, csr_pkg::addr_mcause, '0, 64'd2, 1'b0);
    expect_access("priority", csr_pkg::csrrs, csr_pkg::addr_mepc, '0, model_epc, 1'b0);
    expect_access("priority", csr_pkg::csrrs, csr_pkg::addr_mstatus, '0, model_status(), 1'b0);
    finish_test("priority");

    expect_access("interrupts", csr_pkg::csrrw, csr_pkg::addr_mie, 64'h88, '0, 1'b0);
    expect_access("interrupts", csr_pkg::csrrw, csr_pkg::addr_mstatus, 64'h8,
                  model_status(), 1'b0);
    model_status_write(64'h8);
    @(posedge clk_i);
    timer_irq_i    <= 1'b1;
    software_irq_i <= 1'b1;
    // mip lags the irq inputs by one edge
    @(negedge clk_i);
    check_value("interrupts", 64'd0, 64'(irq_pending_o));
    @(negedge clk_i);
    check_value("interrupts", 64'd1, 64'(irq_pending_o));
    take_interrupt(redirect);
    model_trap();
    check_value("interrupts", 64'd1, 64'(redirect));
    check_value("interrupts", 64'd0, 64'(irq_pending_o));
    check_value("interrupts", model_pc, 64'(npc_o));
    expect_access("interrupts", csr_pkg::csrrs, csr_pkg::addr_mcause, '0,
                  64'h8000_0000_0000_0003, 1'b0);
    expect_access("interrupts", csr_pkg::csrrs, csr_pkg::addr_mepc, '0, model_epc, 1'b0);
    expect_access("interrupts", csr_pkg::csrrs, csr_pkg::addr_mstatus, '0,
                  model_status(), 1'b0);
    @(posedge clk_i);
    timer_irq_i    <= 1'b0;
    software_irq_i <= 1'b0;
    finish_test("interrupts");

    repeat (2) @(posedge clk_i);
    checker_fails = DUT.chk.fail_count;
    $display("tests %0d, passed %0d, failed %0d, value errors %0d, checker failures %0d",
             tests_passed + tests_failed, tests_passed, tests_failed, total_errors,
             checker_fails);
    if (total_errors == 0 && tests_failed == 0 && checker_fails == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule
